/* rtl/net_shell_pkg.sv */
// Network shell shared types
package net_shell_pkg;

    // Register slices between the user region and the stack side
    localparam int N_REG_NET = 2;

    localparam int IP_ADDR_BITS  = 32;
    localparam int MAC_ADDR_BITS = 48;
    localparam int DDR_ADDR_BITS = 64;
    localparam int MEM_LEN_BITS  = 23;
    localparam int STAT_CNT_BITS = 32;

    typedef logic [IP_ADDR_BITS-1:0]  ip_addr_t;
    typedef logic [MAC_ADDR_BITS-1:0] mac_addr_t;
    typedef logic [DDR_ADDR_BITS-1:0] ddr_addr_t;
    typedef logic [MEM_LEN_BITS-1:0]  mem_len_t;
    typedef logic [STAT_CNT_BITS-1:0] stat_cnt_t;

    // Independent configuration strobes from the user side
    typedef struct packed {
        logic      set_ip_valid;
        ip_addr_t  set_ip;
        logic      set_mac_valid;
        mac_addr_t set_mac;
        logic      arp_valid;
        ip_addr_t  arp_ip;
    } net_cfg_req_t;

    // Stack read or write command into its DDR buffer
    typedef struct packed {
        ddr_addr_t addr;
        mem_len_t  len;
    } mem_cmd_t;

    // Merged memory command port
    typedef struct packed {
        logic     write;
        mem_cmd_t cmd;
    } mem_req_t;

    typedef struct packed {
        logic write;
        logic error;
    } mem_sts_t;

    typedef struct packed {
        stat_cnt_t cfg_writes;
        stat_cnt_t rd_cmds;
        stat_cnt_t wr_cmds;
    } net_stat_t;

    typedef enum logic {
        idle,
        wr_pending
    } mem_ctrl_state_t;

endpackage

/* rtl/net_slice_pipe.sv */
// Configuration register slices
`timescale 1ns/1ps

module net_slice_pipe (
    input  logic                        aclk,
    input  logic                        aresetn,
    input  net_shell_pkg::net_cfg_req_t cfg_in,
    input  net_shell_pkg::ddr_addr_t    offset_in,
    output net_shell_pkg::net_cfg_req_t cfg_out,
    output net_shell_pkg::ddr_addr_t    offset_out
);
    import net_shell_pkg::*;

    net_cfg_req_t cfg_stg [N_REG_NET];
    ddr_addr_t    off_stg [N_REG_NET];

    always_ff @(posedge aclk) begin
        cfg_stg[0] <= cfg_in;
        off_stg[0] <= offset_in;
        for (int i = 1; i < N_REG_NET; i++) begin
            cfg_stg[i] <= cfg_stg[i-1];
            off_stg[i] <= off_stg[i-1];
        end
        // Strobes cleared in every stage
        if (!aresetn) begin
            for (int i = 0; i < N_REG_NET; i++) begin
                cfg_stg[i].set_ip_valid  <= 1'b0;
                cfg_stg[i].set_mac_valid <= 1'b0;
                cfg_stg[i].arp_valid     <= 1'b0;
            end
        end
    end

    assign cfg_out    = cfg_stg[N_REG_NET-1];
    assign offset_out = off_stg[N_REG_NET-1];

endmodule

/* rtl/net_cfg_regs.sv */
// Stack address registers
`timescale 1ns/1ps

module net_cfg_regs (
    input  logic                        aclk,
    input  logic                        aresetn,
    input  net_shell_pkg::net_cfg_req_t cfg,
    output net_shell_pkg::ip_addr_t     ip_addr,
    output net_shell_pkg::mac_addr_t    mac_addr,
    output logic                        arp_req_valid,
    output net_shell_pkg::ip_addr_t     arp_req,
    output logic                        cfg_write
);

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            ip_addr       <= '0;
            mac_addr      <= '0;
            arp_req_valid <= 1'b0;
            cfg_write     <= 1'b0;
        end else begin
            if (cfg.set_ip_valid) begin
                ip_addr <= cfg.set_ip;
            end
            if (cfg.set_mac_valid) begin
                mac_addr <= cfg.set_mac;
            end
            arp_req_valid <= cfg.arp_valid;
            // An IP and MAC write in the same cycle give one pulse
            cfg_write     <= cfg.set_ip_valid | cfg.set_mac_valid;
        end
    end

    // Lookup target
    always_ff @(posedge aclk) begin
        if (cfg.arp_valid) begin
            arp_req <= cfg.arp_ip;
        end
    end

endmodule

/* rtl/net_mem_ctrl.sv */
// Memory command controller
`timescale 1ns/1ps

module net_mem_ctrl (
    input  logic                     aclk,
    input  logic                     aresetn,
    input  net_shell_pkg::ddr_addr_t ddr_offset,
    input  logic                     rd_cmd_valid,
    input  net_shell_pkg::mem_cmd_t  rd_cmd,
    input  logic                     wr_cmd_valid,
    input  net_shell_pkg::mem_cmd_t  wr_cmd,
    input  logic                     mem_sts_valid,
    input  net_shell_pkg::mem_sts_t  mem_sts,
    output logic                     mem_req_valid,
    output net_shell_pkg::mem_req_t  mem_req,
    output logic                     rd_sts_valid,
    output logic                     wr_sts_valid,
    output logic                     sts_error
);
    import net_shell_pkg::*;

    mem_ctrl_state_t state_q;
    mem_ctrl_state_t state_d;
    ddr_addr_t       offset_q;
    mem_req_t        rd_req;
    mem_req_t        wr_req;
    mem_req_t        wr_pend_q;
    mem_req_t        req_d;
    logic            req_valid_d;
    logic            pend_load;

    // Offset arrives one stage after the slices
    always_ff @(posedge aclk) begin
        offset_q <= ddr_offset;
    end

    assign rd_req = '{write: 1'b0, cmd: '{addr: rd_cmd.addr + offset_q, len: rd_cmd.len}};
    assign wr_req = '{write: 1'b1, cmd: '{addr: wr_cmd.addr + offset_q, len: wr_cmd.len}};

    // Read wins a collision and the write waits one cycle
    always_comb begin
        state_d     = state_q;
        req_valid_d = 1'b0;
        req_d       = rd_req;
        pend_load   = 1'b0;
        case (state_q)
            idle: begin
                if (rd_cmd_valid) begin
                    req_valid_d = 1'b1;
                    if (wr_cmd_valid) begin
                        pend_load = 1'b1;
                        state_d   = wr_pending;
                    end
                end else if (wr_cmd_valid) begin
                    req_valid_d = 1'b1;
                    req_d       = wr_req;
                end
            end
            // Stack keeps this cycle free of commands
            wr_pending: begin
                req_valid_d = 1'b1;
                req_d       = wr_pend_q;
                state_d     = idle;
            end
            default: state_d = idle;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state_q       <= idle;
            mem_req_valid <= 1'b0;
            rd_sts_valid  <= 1'b0;
            wr_sts_valid  <= 1'b0;
        end else begin
            state_q       <= state_d;
            mem_req_valid <= req_valid_d;
            rd_sts_valid  <= mem_sts_valid & ~mem_sts.write;
            wr_sts_valid  <= mem_sts_valid & mem_sts.write;
        end
    end

    always_ff @(posedge aclk) begin
        mem_req <= req_d;
        if (pend_load) begin
            wr_pend_q <= wr_req;
        end
        if (mem_sts_valid) begin
            sts_error <= mem_sts.error;
        end
    end

endmodule

/* rtl/net_stats.sv */
// Network event counters
`timescale 1ns/1ps

module net_stats (
    input  logic                     aclk,
    input  logic                     aresetn,
    input  logic                     cfg_write,
    input  logic                     mem_req_valid,
    input  net_shell_pkg::mem_req_t  mem_req,
    output net_shell_pkg::net_stat_t stats
);

    logic rd_issued;
    logic wr_issued;

    // Direction taken from the request on the port
    assign rd_issued = mem_req_valid & ~mem_req.write;
    assign wr_issued = mem_req_valid & mem_req.write;

    // All counters wrap
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            stats <= '0;
        end else begin
            if (cfg_write) begin
                stats.cfg_writes <= stats.cfg_writes + 1'b1;
            end
            if (rd_issued) begin
                stats.rd_cmds <= stats.rd_cmds + 1'b1;
            end
            if (wr_issued) begin
                stats.wr_cmds <= stats.wr_cmds + 1'b1;
            end
        end
    end

endmodule

/* rtl/net_shell_top.sv */
// Network shell top level
`timescale 1ns/1ps

module net_shell_top (
    input  logic                        aclk,
    input  logic                        aresetn,
    input  net_shell_pkg::net_cfg_req_t cfg_req,
    input  net_shell_pkg::ddr_addr_t    ddr_offset,
    input  logic                        rd_cmd_valid,
    input  net_shell_pkg::mem_cmd_t     rd_cmd,
    input  logic                        wr_cmd_valid,
    input  net_shell_pkg::mem_cmd_t     wr_cmd,
    input  logic                        mem_sts_valid,
    input  net_shell_pkg::mem_sts_t     mem_sts,
    output net_shell_pkg::ip_addr_t     ip_addr,
    output net_shell_pkg::mac_addr_t    mac_addr,
    output logic                        arp_req_valid,
    output net_shell_pkg::ip_addr_t     arp_req,
    output logic                        mem_req_valid,
    output net_shell_pkg::mem_req_t     mem_req,
    output logic                        rd_sts_valid,
    output logic                        wr_sts_valid,
    output logic                        sts_error,
    output net_shell_pkg::net_stat_t    net_stats
);
    import net_shell_pkg::*;

    net_cfg_req_t cfg_slice;
    ddr_addr_t    offset_slice;
    logic         cfg_write;

    // Retiming from the user region
    net_slice_pipe u_pipe (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .cfg_in     (cfg_req),
        .offset_in  (ddr_offset),
        .cfg_out    (cfg_slice),
        .offset_out (offset_slice)
    );

    net_cfg_regs u_cfg (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .cfg           (cfg_slice),
        .ip_addr       (ip_addr),
        .mac_addr      (mac_addr),
        .arp_req_valid (arp_req_valid),
        .arp_req       (arp_req),
        .cfg_write     (cfg_write)
    );

    net_mem_ctrl u_mem (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .ddr_offset    (offset_slice),
        .rd_cmd_valid  (rd_cmd_valid),
        .rd_cmd        (rd_cmd),
        .wr_cmd_valid  (wr_cmd_valid),
        .wr_cmd        (wr_cmd),
        .mem_sts_valid (mem_sts_valid),
        .mem_sts       (mem_sts),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .rd_sts_valid  (rd_sts_valid),
        .wr_sts_valid  (wr_sts_valid),
        .sts_error     (sts_error)
    );

    net_stats u_stats (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .cfg_write     (cfg_write),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .stats         (net_stats)
    );

endmodule

/* sim/net_shell_tb.sv */
// Network shell testbench
`timescale 1ns/1ps

module net_shell_tb;
    import net_shell_pkg::*;

    localparam int N_CFG  = 5;
    localparam int N_LONE = 60;
    localparam int N_COLL = 12;
    localparam int N_STS  = 4;
    localparam int N_OPS  = N_CFG + N_LONE + N_COLL + N_STS;
    localparam int TIMEOUT_CYCLES = N_OPS * 10 + 200;

    typedef struct packed {
        mem_req_t req;
        int       due;
    } exp_req_t;

    logic         aclk = 1'b0;
    logic         aresetn;
    net_cfg_req_t cfg_req;
    ddr_addr_t    ddr_offset;
    logic         rd_cmd_valid;
    mem_cmd_t     rd_cmd;
    logic         wr_cmd_valid;
    mem_cmd_t     wr_cmd;
    logic         mem_sts_valid;
    mem_sts_t     mem_sts;
    ip_addr_t     ip_addr;
    mac_addr_t    mac_addr;
    logic         arp_req_valid;
    ip_addr_t     arp_req;
    logic         mem_req_valid;
    mem_req_t     mem_req;
    logic         rd_sts_valid;
    logic         wr_sts_valid;
    logic         sts_error;
    net_stat_t    net_stats;

    integer       seed = 32'hc4a426ac;
    int           errors = 0;
    int           checks = 0;
    int           cyc = 0;
    int           cfg_cnt = 0;
    int           rd_cnt = 0;
    int           wr_cnt = 0;
    ip_addr_t     ip_model = '0;
    mac_addr_t    mac_model = '0;
    ddr_addr_t    off_hist [3];
    exp_req_t     exp_q [$];

    net_shell_top u_dut (.*);

    always #20 aclk = ~aclk;

    // Offset seen by a command three cycles on
    always @(posedge aclk) begin
        off_hist[0] <= ddr_offset;
        off_hist[1] <= off_hist[0];
        off_hist[2] <= off_hist[1];
        cyc         <= cyc + 1;
    end

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    function automatic mem_req_t ref_mem_req(input mem_cmd_t cmd, input logic write,
                                             input ddr_addr_t offset);
        mem_req_t r;
        r.write    = write;
        r.cmd.addr = cmd.addr + offset;
        r.cmd.len  = cmd.len;
        return r;
    endfunction

    function automatic ddr_addr_t rand_addr();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = $random(seed);
        lo = $random(seed);
        return {hi, lo};
    endfunction

    function automatic mem_cmd_t rand_cmd();
        logic [31:0] r;
        mem_cmd_t    c;
        c.addr = rand_addr();
        r      = $random(seed);
        c.len  = r[MEM_LEN_BITS-1:0];
        return c;
    endfunction

    // One cycle of commands with a possible offset move
    task automatic send_cmds(input logic do_rd, input logic do_wr);
        mem_cmd_t    rc;
        mem_cmd_t    wc;
        logic [31:0] r;
        exp_req_t    e;
        @(negedge aclk);
        rc = rand_cmd();
        wc = rand_cmd();
        rd_cmd_valid = do_rd;
        rd_cmd       = rc;
        wr_cmd_valid = do_wr;
        wr_cmd       = wc;
        r = $random(seed);
        if (r[0]) begin
            ddr_offset = rand_addr();
        end
        if (do_rd) begin
            e.req = ref_mem_req(rc, 1'b0, off_hist[2]);
            e.due = cyc + 1;
            exp_q.push_back(e);
            rd_cnt++;
        end
        if (do_wr) begin
            e.req = ref_mem_req(wc, 1'b1, off_hist[2]);
            // Write trails a colliding read by one cycle
            e.due = do_rd ? cyc + 2 : cyc + 1;
            exp_q.push_back(e);
            wr_cnt++;
        end
    endtask

    task automatic cfg_check(input logic do_ip, input logic do_mac, input logic do_arp);
        logic [31:0] r0;
        logic [31:0] r1;
        ip_addr_t    ip_v;
        mac_addr_t   mac_v;
        ip_addr_t    arp_v;
        @(negedge aclk);
        ip_v  = $random(seed);
        r0    = $random(seed);
        r1    = $random(seed);
        mac_v = {r0[15:0], r1};
        arp_v = $random(seed);
        cfg_req = '{set_ip_valid: do_ip, set_ip: ip_v, set_mac_valid: do_mac,
                    set_mac: mac_v, arp_valid: do_arp, arp_ip: arp_v};
        @(negedge aclk);
        cfg_req.set_ip_valid  = 1'b0;
        cfg_req.set_mac_valid = 1'b0;
        cfg_req.arp_valid     = 1'b0;
        @(negedge aclk);
        check_value("ip_addr", 128'(ip_addr), 128'(ip_model));
        check_value("mac_addr", 128'(mac_addr), 128'(mac_model));
        check_value("arp_req_valid", 128'(arp_req_valid), 128'(1'b0));
        if (do_ip) ip_model = ip_v;
        if (do_mac) mac_model = mac_v;
        if (do_ip || do_mac) cfg_cnt++;
        @(negedge aclk);
        check_value("ip_addr", 128'(ip_addr), 128'(ip_model));
        check_value("mac_addr", 128'(mac_addr), 128'(mac_model));
        check_value("arp_req_valid", 128'(arp_req_valid), 128'(do_arp));
        if (do_arp) check_value("arp_req", 128'(arp_req), 128'(arp_v));
        @(negedge aclk);
        check_value("arp_req_valid", 128'(arp_req_valid), 128'(1'b0));
    endtask

    task automatic sts_check(input logic write, input logic error);
        @(negedge aclk);
        mem_sts_valid = 1'b1;
        mem_sts       = '{write: write, error: error};
        @(negedge aclk);
        mem_sts_valid = 1'b0;
        check_value("rd_sts_valid", 128'(rd_sts_valid), 128'(!write));
        check_value("wr_sts_valid", 128'(wr_sts_valid), 128'(write));
        check_value("sts_error", 128'(sts_error), 128'(error));
        @(negedge aclk);
        check_value("rd_sts_valid", 128'(rd_sts_valid), 128'(1'b0));
        check_value("wr_sts_valid", 128'(wr_sts_valid), 128'(1'b0));
    endtask

    // Every issued request against the expected queue
    always @(negedge aclk) begin
        exp_req_t e;
        if (aresetn) begin
            if (mem_req_valid) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Unexpected memory request at cycle %0d", cyc);
                end else begin
                    e = exp_q.pop_front();
                    check_value("mem_req", 128'(mem_req), 128'(e.req));
                    if (e.due != cyc) begin
                        errors++;
                        $display("Memory request came at cycle %0d, due at %0d", cyc, e.due);
                    end
                end
            end else if (exp_q.size() != 0 && exp_q[0].due <= cyc) begin
                errors++;
                $display("Memory request due at cycle %0d never came", exp_q[0].due);
                void'(exp_q.pop_front());
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge aclk);
        $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        aresetn       = 1'b0;
        cfg_req       = '0;
        ddr_offset    = '0;
        rd_cmd_valid  = 1'b0;
        rd_cmd        = '0;
        wr_cmd_valid  = 1'b0;
        wr_cmd        = '0;
        mem_sts_valid = 1'b0;
        mem_sts       = '0;
        repeat (5) @(negedge aclk);
        aresetn = 1'b1;
        @(negedge aclk);
        check_value("mem_req_valid", 128'(mem_req_valid), 128'(1'b0));
        check_value("arp_req_valid", 128'(arp_req_valid), 128'(1'b0));
        check_value("rd_sts_valid", 128'(rd_sts_valid), 128'(1'b0));
        check_value("wr_sts_valid", 128'(wr_sts_valid), 128'(1'b0));
        check_value("ip_addr", 128'(ip_addr), 128'(0));
        check_value("mac_addr", 128'(mac_addr), 128'(0));
        check_value("net_stats", 128'(net_stats), 128'(0));

        cfg_check(1'b1, 1'b0, 1'b0);
        cfg_check(1'b0, 1'b1, 1'b0);
        cfg_check(1'b1, 1'b1, 1'b0);
        cfg_check(1'b0, 1'b0, 1'b1);
        cfg_check(1'b1, 1'b1, 1'b1);

        for (int i = 0; i < N_LONE; i++) begin
            logic [31:0] r;
            r = $random(seed);
            send_cmds(!r[0], r[0]);
            if (r[2]) send_cmds(1'b0, 1'b0);
        end
        // Stack leaves the cycle after a collision free
        for (int i = 0; i < N_COLL; i++) begin
            send_cmds(1'b1, 1'b1);
            send_cmds(1'b0, 1'b0);
        end
        repeat (4) send_cmds(1'b0, 1'b0);

        sts_check(1'b0, 1'b0);
        sts_check(1'b0, 1'b1);
        sts_check(1'b1, 1'b0);
        sts_check(1'b1, 1'b1);

        check_value("net_stats.cfg_writes", 128'(net_stats.cfg_writes), 128'(cfg_cnt));
        check_value("net_stats.rd_cmds", 128'(net_stats.rd_cmds), 128'(rd_cnt));
        check_value("net_stats.wr_cmds", 128'(net_stats.wr_cmds), 128'(wr_cnt));

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* net_shell.f */
rtl/net_shell_pkg.sv
rtl/net_slice_pipe.sv
rtl/net_cfg_regs.sv
rtl/net_mem_ctrl.sv
rtl/net_stats.sv
rtl/net_shell_top.sv
sim/net_shell_tb.sv

/* Makefile */
# Verilator build for the network shell

TOP = net_shell_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -sv -f net_shell.f --top-module $(TOP)

sim:
	verilator --binary --timing -sv -f net_shell.f --top-module $(TOP) \
		-Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -qx "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log
